/* rtl/up_pkg.sv */
package up_pkg;

   localparam int DATA_W    = 8;
   localparam int NIB_W     = 4;
   localparam int OP_W      = 5;
   localparam int SEL_W     = 3;
   localparam int MEM_DEPTH = 1 << DATA_W;

   // Datapath op codes
   localparam logic [OP_W-1:0] OP_ADD        = 5'h00;
   localparam logic [OP_W-1:0] OP_SUB        = 5'h01;
   localparam logic [OP_W-1:0] OP_MUL        = 5'h02;
   localparam logic [OP_W-1:0] OP_DIV        = 5'h03;
   localparam logic [OP_W-1:0] OP_NAND       = 5'h04;
   localparam logic [OP_W-1:0] OP_XOR01      = 5'h05;
   localparam logic [OP_W-1:0] OP_XOR12      = 5'h06;
   localparam logic [OP_W-1:0] OP_XOR23      = 5'h07;
   localparam logic [OP_W-1:0] OP_XORS3      = 5'h08;
   localparam logic [OP_W-1:0] OP_XORP3      = 5'h09;
   localparam logic [OP_W-1:0] OP_SP_INC     = 5'h0A;
   localparam logic [OP_W-1:0] OP_SP_DEC     = 5'h0B;
   localparam logic [OP_W-1:0] OP_PC         = 5'h0C;
   localparam logic [OP_W-1:0] OP_FETCH_ADDR = 5'h0D;  // Program half
   localparam logic [OP_W-1:0] OP_TABLE_ADDR = 5'h0E;  // Table half
   localparam logic [OP_W-1:0] OP_PC_INC     = 5'h0F;
   localparam logic [OP_W-1:0] OP_PASS       = 5'h10;  // data_in

   // Write select codes I take memory and O take the result
   localparam logic [SEL_W-1:0] SEL_I0 = 3'd0;
   localparam logic [SEL_W-1:0] SEL_I1 = 3'd1;
   localparam logic [SEL_W-1:0] SEL_I2 = 3'd2;
   localparam logic [SEL_W-1:0] SEL_I3 = 3'd3;
   localparam logic [SEL_W-1:0] SEL_O0 = 3'd4;
   localparam logic [SEL_W-1:0] SEL_O1 = 3'd5;
   localparam logic [SEL_W-1:0] SEL_O2 = 3'd6;
   localparam logic [SEL_W-1:0] SEL_O3 = 3'd7;

   localparam logic [NIB_W-1:0] I_ADD  = 4'h0;
   localparam logic [NIB_W-1:0] I_SUB  = 4'h1;
   localparam logic [NIB_W-1:0] I_MUL  = 4'h2;
   localparam logic [NIB_W-1:0] I_DIV  = 4'h3;
   localparam logic [NIB_W-1:0] I_NAND = 4'h4;
   localparam logic [NIB_W-1:0] I_X01  = 4'h5;
   localparam logic [NIB_W-1:0] I_X12  = 4'h6;
   localparam logic [NIB_W-1:0] I_X23  = 4'h7;
   localparam logic [NIB_W-1:0] I_XS3  = 4'h8;
   localparam logic [NIB_W-1:0] I_XP3  = 4'h9;
   localparam logic [NIB_W-1:0] I_SPI  = 4'hA;
   localparam logic [NIB_W-1:0] I_SPD  = 4'hB;
   localparam logic [NIB_W-1:0] I_LDT  = 4'hC;
   localparam logic [NIB_W-1:0] I_LDX  = 4'hD;
   localparam logic [NIB_W-1:0] I_JMPT = 4'hE;
   localparam logic [NIB_W-1:0] I_HALT = 4'hF;

   localparam logic [DATA_W-1:0] PC_RST = 8'h00;
   localparam logic [DATA_W-1:0] SP_RST = 8'hFF;
   localparam logic [DATA_W-1:0] R0_RST = 8'h01;
   localparam logic [DATA_W-1:0] R1_RST = 8'h02;
   localparam logic [DATA_W-1:0] R2_RST = 8'h03;
   localparam logic [DATA_W-1:0] R3_RST = 8'h04;
   localparam logic [NIB_W-1:0]  IR_RST = 4'h0;

   typedef enum logic [2:0] {
      S_FETCH,
      S_DECODE,
      S_EXEC,
      S_LOAD,
      S_HALT
   } up_state_t;

endpackage

/* rtl/up_ctrl_if.sv */
`timescale 1ns/100ps

interface up_ctrl_if
   import up_pkg::*;
();

   logic [OP_W-1:0]  op;      // Result mux select
   logic             ir_we;
   logic             pc_we;
   logic             sp_we;
   logic             rb_we;   // General register write
   logic [SEL_W-1:0] rb_sel;

   modport ctl (
      output op, ir_we, pc_we, sp_we, rb_we, rb_sel
   );

   modport dp (
      input  op, ir_we, pc_we, sp_we, rb_we, rb_sel
   );

endinterface

/* rtl/up_datapath.sv */
`timescale 1ns/100ps

module up_datapath
   import up_pkg::*;
(
   input  logic              clk,
   input  logic              nRst,
   up_ctrl_if.dp             ctrl,
   input  logic [DATA_W-1:0] data_in,
   output logic [DATA_W-1:0] data_out,
   output logic [NIB_W-1:0]  ir
);

   logic [DATA_W-1:0] pc;
   logic [DATA_W-1:0] sp;
   logic [DATA_W-1:0] r0;
   logic [DATA_W-1:0] r1;
   logic [DATA_W-1:0] r2;
   logic [DATA_W-1:0] r3;
   logic [DATA_W-1:0] quot;

   // Divide by zero saturates to all ones
   assign quot = (r2 == '0) ? {DATA_W{1'b1}} : r1 / r2;

   always_comb begin
      case (ctrl.op)
         OP_ADD:        data_out = r1 + r2;
         OP_SUB:        data_out = r1 - r2;
         OP_MUL:        data_out = r1 * r2;           // Low byte only
         OP_DIV:        data_out = quot;
         OP_NAND:       data_out = ~(r1 & r2);
         OP_XOR01:      data_out = r0 ^ r1;
         OP_XOR12:      data_out = r1 ^ r2;
         OP_XOR23:      data_out = r2 ^ r3;
         OP_XORS3:      data_out = sp ^ r3;
         OP_XORP3:      data_out = pc ^ r3;
         OP_SP_INC:     data_out = sp + DATA_W'(1);
         OP_SP_DEC:     data_out = sp - DATA_W'(1);
         OP_PC:         data_out = pc;
         OP_FETCH_ADDR: data_out = {1'b0, pc[DATA_W-1:1]};
         OP_TABLE_ADDR: data_out = {1'b1, pc[DATA_W-1:1]};
         OP_PC_INC:     data_out = pc + DATA_W'(1);
         default:       data_out = data_in;
      endcase
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         pc <= PC_RST;
         sp <= SP_RST;
         ir <= IR_RST;
         r0 <= R0_RST;
         r1 <= R1_RST;
         r2 <= R2_RST;
         r3 <= R3_RST;
      end else begin
         if (ctrl.ir_we) begin
            // Even pc takes the high nibble
            if (pc[0]) begin
               ir <= data_in[NIB_W-1:0];
            end else begin
               ir <= data_in[DATA_W-1:NIB_W];
            end
         end
         if (ctrl.pc_we) begin
            pc <= data_out;
         end
         if (ctrl.sp_we) begin
            sp <= data_out;
         end
         if (ctrl.rb_we) begin
            case (ctrl.rb_sel)
               SEL_I0:  r0 <= data_in;
               SEL_I1:  r1 <= data_in;
               SEL_I2:  r2 <= data_in;
               SEL_I3:  r3 <= data_in;
               SEL_O0:  r0 <= data_out;
               SEL_O1:  r1 <= data_out;
               SEL_O2:  r2 <= data_out;
               SEL_O3:  r3 <= data_out;
               default: r0 <= r0;
            endcase
         end
      end
   end

endmodule

/* rtl/up_control.sv */
`timescale 1ns/100ps

module up_control
   import up_pkg::*;
(
   input  logic             clk,
   input  logic             nRst,
   up_ctrl_if.ctl           ctrl,
   input  logic [NIB_W-1:0] ir,
   output logic             mar_we,
   output logic             retire,
   output logic             halted,
   output logic [NIB_W-1:0] retire_ir
);

   up_state_t        state;
   up_state_t        state_nxt;
   logic [OP_W-1:0]  exec_op;
   logic [SEL_W-1:0] exec_sel;
   logic             alu_form;
   logic             sp_form;
   logic             mem_form;

   assign alu_form = (ir <= I_XP3);                          // Writes a general register
   assign sp_form  = (ir == I_SPI) || (ir == I_SPD);
   assign mem_form = (ir == I_LDT) || (ir == I_LDX) || (ir == I_JMPT);

   // Decode-loaded ir stays stable through exec and load
   assign retire_ir = ir;
   assign halted    = (state == S_HALT);

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state <= S_FETCH;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      case (state)
         S_FETCH:  state_nxt = S_DECODE;
         S_DECODE: state_nxt = S_EXEC;
         S_EXEC: begin
            if (ir == I_HALT) begin
               state_nxt = S_HALT;
            end else if (mem_form) begin
               state_nxt = S_LOAD;
            end else begin
               state_nxt = S_FETCH;
            end
         end
         S_LOAD:   state_nxt = S_FETCH;
         S_HALT:   state_nxt = S_HALT;                       // Left only by reset
         default:  state_nxt = S_FETCH;
      endcase
   end

   // Nibble to datapath op
   always_comb begin
      case (ir)
         I_ADD:  exec_op = OP_ADD;
         I_SUB:  exec_op = OP_SUB;
         I_MUL:  exec_op = OP_MUL;
         I_DIV:  exec_op = OP_DIV;
         I_NAND: exec_op = OP_NAND;
         I_X01:  exec_op = OP_XOR01;
         I_X12:  exec_op = OP_XOR12;
         I_X23:  exec_op = OP_XOR23;
         I_XS3:  exec_op = OP_XORS3;
         I_XP3:  exec_op = OP_XORP3;
         I_SPI:  exec_op = OP_SP_INC;
         I_SPD:  exec_op = OP_SP_DEC;
         I_LDT:  exec_op = OP_TABLE_ADDR;
         I_LDX:  exec_op = OP_XORS3;                         // Index address sp ^ r3
         I_JMPT: exec_op = OP_TABLE_ADDR;
         I_HALT: exec_op = OP_PC;                            // Reports pc on retire
      endcase
   end

   always_comb begin
      case (ir)
         I_ADD, I_SUB, I_MUL, I_DIV, I_NAND: exec_sel = SEL_O0;
         I_X01, I_X12, I_X23:                exec_sel = SEL_O3;
         I_XS3, I_XP3:                       exec_sel = SEL_O2;
         I_LDT:                              exec_sel = SEL_I1;
         I_LDX:                              exec_sel = SEL_I2;
         default:                            exec_sel = SEL_O0;
      endcase
   end

   always_comb begin
      ctrl.op     = OP_PASS;
      ctrl.ir_we  = 1'b0;
      ctrl.pc_we  = 1'b0;
      ctrl.sp_we  = 1'b0;
      ctrl.rb_we  = 1'b0;
      ctrl.rb_sel = SEL_O0;
      mar_we      = 1'b0;
      retire      = 1'b0;
      case (state)
         S_FETCH: begin
            ctrl.op = OP_FETCH_ADDR;
            mar_we  = 1'b1;
         end
         S_DECODE: begin
            ctrl.op    = OP_PC_INC;
            ctrl.ir_we = 1'b1;
            ctrl.pc_we = 1'b1;
         end
         S_EXEC: begin
            ctrl.op     = exec_op;
            ctrl.rb_sel = exec_sel;
            if (mem_form) begin
               mar_we = 1'b1;                                // Operand address first
            end else begin
               ctrl.rb_we = alu_form;
               ctrl.sp_we = sp_form;
               retire     = 1'b1;
            end
         end
         S_LOAD: begin
            ctrl.op     = OP_PASS;
            ctrl.rb_sel = exec_sel;
            ctrl.rb_we  = (ir != I_JMPT);
            ctrl.pc_we  = (ir == I_JMPT);
            retire      = 1'b1;
         end
         default: begin
            ctrl.op = OP_PASS;
         end
      endcase
   end

endmodule

/* rtl/up_memory.sv */
`timescale 1ns/100ps

module up_memory
   import up_pkg::*;
(
   input  logic              clk,
   input  logic [DATA_W-1:0] addr,
   input  logic              mar_we,
   input  logic              load_we,
   input  logic [DATA_W-1:0] load_addr,
   input  logic [DATA_W-1:0] load_data,
   output logic [DATA_W-1:0] rdata
);

   logic [DATA_W-1:0] mar;
   logic [DATA_W-1:0] mem [MEM_DEPTH];

   always_ff @(posedge clk) begin
      if (mar_we) begin
         mar <= addr;
      end
   end

   // Loaded by the testbench while the core sits in reset
   always_ff @(posedge clk) begin
      if (load_we) begin
         mem[load_addr] <= load_data;
      end
   end

   assign rdata = mem[mar];                                  // Asynchronous read

endmodule

/* rtl/up_cpu.sv */
`timescale 1ns/100ps

module up_cpu
   import up_pkg::*;
(
   input  logic              clk,
   input  logic              nRst,
   input  logic              load_we,
   input  logic [DATA_W-1:0] load_addr,
   input  logic [DATA_W-1:0] load_data,
   output logic              retire,
   output logic [NIB_W-1:0]  retire_ir,
   output logic [DATA_W-1:0] retire_value,
   output logic              halted
);

   logic [DATA_W-1:0] result;
   logic [DATA_W-1:0] mem_data;
   logic [NIB_W-1:0]  ir;
   logic              mar_we;

   up_ctrl_if ctrl_bus ();

   up_control up_control_inst (
      .clk       (clk),
      .nRst      (nRst),
      .ctrl      (ctrl_bus.ctl),
      .ir        (ir),
      .mar_we    (mar_we),
      .retire    (retire),
      .halted    (halted),
      .retire_ir (retire_ir)
   );

   up_datapath up_datapath_inst (
      .clk      (clk),
      .nRst     (nRst),
      .ctrl     (ctrl_bus.dp),
      .data_in  (mem_data),
      .data_out (result),
      .ir       (ir)
   );

   // Result bus doubles as the memory address
   up_memory up_memory_inst (
      .clk       (clk),
      .addr      (result),
      .mar_we    (mar_we),
      .load_we   (load_we),
      .load_addr (load_addr),
      .load_data (load_data),
      .rdata     (mem_data)
   );

   assign retire_value = result;

endmodule

/* tb/up_cpu_chk.sv */
`timescale 1ns/100ps

module up_cpu_chk
   import up_pkg::*;
(
   input logic      clk,
   input logic      nRst,
   input up_state_t state,
   input logic      retire,
   input logic      halted,
   input logic      ir_we,
   input logic      rb_we
);

   int fail_count = 0;

   retire_gap: assert property (@(posedge clk) disable iff (!nRst)
      retire |=> !retire ##1 !retire)
      else begin
         fail_count = fail_count + 1;
         $error("Retire pulses closer than 3 cycles");
      end

   halt_sticky: assert property (@(posedge clk) disable iff (!nRst) halted |=> halted)
      else begin
         fail_count = fail_count + 1;
         $error("Halted fell without reset");
      end

   halt_quiet: assert property (@(posedge clk) disable iff (!nRst) halted |-> !retire)
      else begin
         fail_count = fail_count + 1;
         $error("Retire while halted");
      end

   // Instruction load and register write never share a cycle
   strobe_excl: assert property (@(posedge clk) disable iff (!nRst) !(ir_we && rb_we))
      else begin
         fail_count = fail_count + 1;
         $error("ir_we and rb_we high together");
      end

   // Retire marks the last cycle of an instruction
   retire_last: assert property (@(posedge clk) disable iff (!nRst)
      retire |=> (state == S_FETCH || state == S_HALT))
      else begin
         fail_count = fail_count + 1;
         $error("Retire not followed by fetch or halt");
      end

endmodule

/* tb/up_model_check.sv */
`timescale 1ns/100ps

module up_model_check
   import up_pkg::*;
(
   input  logic              clk,
   input  logic              nRst,
   input  logic              load_we,
   input  logic [DATA_W-1:0] load_addr,
   input  logic [DATA_W-1:0] load_data,
   input  logic              retire,
   input  logic [NIB_W-1:0]  retire_ir,
   input  logic [DATA_W-1:0] retire_value,
   input  logic              halted,
   output int                error_count,
   output int                retire_count
);

   logic [DATA_W-1:0] mem [MEM_DEPTH];
   logic [DATA_W-1:0] pc, sp, r0, r1, r2, r3;
   logic              model_halted;
   logic [NIB_W-1:0]  exp_ir;
   logic [DATA_W-1:0] exp_val;

   initial begin
      error_count  = 0;
      retire_count = 0;
   end

   task automatic step_model(output logic [NIB_W-1:0] nib, output logic [DATA_W-1:0] value);
      logic [DATA_W-1:0] word;
      word  = mem[{1'b0, pc[7:1]}];
      nib   = pc[0] ? word[3:0] : word[7:4];    // High nibble at even pc
      pc    = pc + 8'd1;
      value = 8'h00;
      case (nib)
         I_ADD:  value = r1 + r2;
         I_SUB:  value = r1 - r2;
         I_MUL:  value = r1 * r2;
         I_DIV:  value = (r2 == 8'd0) ? 8'hFF : r1 / r2;
         I_NAND: value = ~(r1 & r2);
         I_X01:  value = r0 ^ r1;
         I_X12:  value = r1 ^ r2;
         I_X23:  value = r2 ^ r3;
         I_XS3:  value = sp ^ r3;
         I_XP3:  value = pc ^ r3;
         I_SPI:  value = sp + 8'd1;
         I_SPD:  value = sp - 8'd1;
         I_LDT:  value = mem[{1'b1, pc[7:1]}];
         I_LDX:  value = mem[sp ^ r3];
         I_JMPT: value = mem[{1'b1, pc[7:1]}];
         I_HALT: value = pc;
      endcase
      case (nib)
         I_ADD, I_SUB, I_MUL, I_DIV, I_NAND: r0 = value;
         I_X01, I_X12, I_X23:                r3 = value;
         I_XS3, I_XP3, I_LDX:                r2 = value;
         I_SPI, I_SPD:                       sp = value;
         I_LDT:                              r1 = value;
         I_JMPT:                             pc = value;
         I_HALT:                             model_halted = 1'b1;
      endcase
   endtask

   always @(posedge clk) begin
      if (load_we) begin
         mem[load_addr] = load_data;             // Shadow of the loaded image
      end
      if (!nRst) begin
         pc = PC_RST;
         sp = SP_RST;
         r0 = R0_RST;
         r1 = R1_RST;
         r2 = R2_RST;
         r3 = R3_RST;
         model_halted = 1'b0;
         retire_count = 0;
      end else begin
         if (halted !== model_halted) begin
            $display("ERROR %0t: halted is %b, model expects %b", $time, halted, model_halted);
            error_count++;
         end
         if (retire === 1'b1) begin
            if (model_halted) begin
               $display("ERROR %0t: retire seen after HALT", $time);
               error_count++;
            end else begin
               step_model(exp_ir, exp_val);
               retire_count++;
               if (retire_ir !== exp_ir || retire_value !== exp_val) begin
                  $display("ERROR %0t: retire %0d gave ir %h value %h, expected ir %h value %h",
                           $time, retire_count, retire_ir, retire_value, exp_ir, exp_val);
                  error_count++;
               end
            end
         end
      end
   end

endmodule

/* tb/up_tb.sv */
`timescale 1ns/100ps

module up_tb
   import up_pkg::*;
();

   localparam int TIMEOUT      = 2000;
   localparam int RETIRE_LIMIT = 300;

   logic              clk, nRst, load_we, retire, halted;
   logic [DATA_W-1:0] load_addr, load_data, retire_value;
   logic [NIB_W-1:0]  retire_ir;
   int                error_count, retire_count, seed, tests, fails, pos;
   logic [NIB_W-1:0]  prog [256];                        // Nibble image of the lower half
   logic [DATA_W-1:0] tbl [128];

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   up_cpu up_cpu_inst (
      .clk(clk), .nRst(nRst), .load_we(load_we), .load_addr(load_addr),
      .load_data(load_data), .retire(retire), .retire_ir(retire_ir),
      .retire_value(retire_value), .halted(halted)
   );

   up_model_check model_check_inst (
      .clk(clk), .nRst(nRst), .load_we(load_we), .load_addr(load_addr),
      .load_data(load_data), .retire(retire), .retire_ir(retire_ir),
      .retire_value(retire_value), .halted(halted), .error_count(error_count),
      .retire_count(retire_count)
   );

   bind up_control up_cpu_chk cpu_chk_inst (
      .clk(clk), .nRst(nRst), .state(state), .retire(retire), .halted(halted),
      .ir_we(ctrl.ir_we), .rb_we(ctrl.rb_we)
   );

   function automatic int pick(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   task automatic put(input logic [NIB_W-1:0] nib);
      prog[pos] = nib;
      pos++;
   endtask

   task automatic new_program();
      pos = 0;
      for (int i = 0; i < 256; i++) begin
         prog[i] = I_HALT;                               // Runaway code stops
      end
      for (int i = 0; i < 128; i++) begin
         tbl[i] = 8'($random(seed));
      end
   endtask

   task automatic load_and_reset();
      nRst = 1'b0;
      for (int i = 0; i < 256; i++) begin
         @(negedge clk);
         load_we   = 1'b1;
         load_addr = 8'(i);
         load_data = (i < 128) ? {prog[2*i], prog[2*i+1]} : tbl[i-128];
      end
      @(negedge clk);
      load_we = 1'b0;
      repeat (16) @(negedge clk);
      nRst = 1'b1;
   endtask

   task automatic run_program(output bit done);
      int cycles;
      cycles = 0;
      while (halted !== 1'b1 && retire_count < RETIRE_LIMIT && cycles < TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      done = (halted === 1'b1) || (retire_count >= RETIRE_LIMIT);
      if (!done) begin
         $display("Test %0d timed out: no halt and no %0d retires within %0d cycles",
                  tests + 1, RETIRE_LIMIT, TIMEOUT);
         fails++;
      end
   endtask

   task automatic end_test(input string name, input int err0, input int fail0);
      tests++;
      if (error_count == err0 && fails == fail0) begin
         $display("Test %0d %s: passed after %0d retires", tests, name, retire_count);
      end else begin
         $display("Test %0d %s: failed", tests, name);
      end
   endtask

   initial begin
      int  len, e0, f0, quiet, chk_fails;
      bit  done, still;
      logic [NIB_W-1:0] nib;
      seed = 32'h0c2a2c51;
      nRst = 1'b0;
      load_we = 1'b0;
      load_addr = '0;
      load_data = '0;
      tests = 0;
      fails = 0;
      @(negedge clk);

      e0 = error_count;
      f0 = fails;
      new_program();                                     // ALU ops followed by HALT
      len = 40 + pick(40);
      for (int k = 0; k < len; k++) put(4'(pick(10)));
      load_and_reset();
      run_program(done);
      if (done && (halted !== 1'b1 || retire_count != len + 1)) begin
         $display("ERROR %0t: ALU program ended after %0d retires, expected halt after %0d",
                  $time, retire_count, len + 1);
         fails++;
      end
      end_test("ALU program", e0, f0);

      e0 = error_count;
      f0 = fails;
      new_program();
      put(I_SPI);                                        // FF wraps to 00
      put(I_XS3);
      put(I_SPD);                                        // 00 wraps to FF
      put(I_SPD);
      put(I_XS3);
      while (pos < 200) begin
         nib = pick(2) ? I_SPI : I_SPD;
         repeat (1 + pick(8)) put(nib);
         put(I_XS3);
      end
      load_and_reset();
      run_program(done);
      end_test("stack operations", e0, f0);

      e0 = error_count;
      f0 = fails;
      new_program();
      while (pos < 180) begin
         case (pick(5))
            0: put(I_LDT);
            1: put(I_LDX);
            2: put(I_X23);
            3: put(I_SPD);
            default: put(4'(pick(10)));
         endcase
      end
      load_and_reset();
      run_program(done);
      end_test("table and indexed loads", e0, f0);

      e0 = error_count;
      f0 = fails;
      new_program();
      while (pos < 256) begin
         len = pick(40);
         if (len == 0) put(I_HALT);
         else if (len < 12) put(I_JMPT);
         else if (len < 16) put(I_LDT);
         else put(4'(pick(10)));
      end
      load_and_reset();
      run_program(done);
      end_test("jumps", e0, f0);

      e0 = error_count;
      f0 = fails;
      new_program();
      tbl[7'(SP_RST ^ R3_RST)] = 8'h00;                  // LDX after reset clears r2
      put(I_LDX);
      put(I_DIV);
      put(I_HALT);
      load_and_reset();
      run_program(done);
      quiet = retire_count;
      still = (halted === 1'b1);
      for (int k = 0; k < 50; k++) begin
         @(negedge clk);
         if (halted !== 1'b1) still = 1'b0;
      end
      if (!still || retire_count != quiet) begin
         $display("Core did not stay halted and quiet for 50 cycles after HALT");
         fails++;
      end
      end_test("division by zero and halt", e0, f0);

      for (int p = 0; p < 4; p++) begin
         e0 = error_count;
         f0 = fails;
         new_program();
         while (pos < 256) put(4'(pick(16)));
         load_and_reset();
         run_program(done);
         end_test($sformatf("random program %0d", p), e0, f0);
      end

      chk_fails = up_cpu_inst.up_control_inst.cpu_chk_inst.fail_count;
      $display("Done: %0d tests, %0d model errors, %0d other failures, %0d assertion failures",
               tests, error_count, fails, chk_fails);
      if (error_count == 0 && fails == 0 && chk_fails == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

/* list.f */
rtl/up_pkg.sv
rtl/up_ctrl_if.sv
rtl/up_datapath.sv
rtl/up_control.sv
rtl/up_memory.sv
rtl/up_cpu.sv
tb/up_cpu_chk.sv
tb/up_model_check.sv
tb/up_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module up_tb -f list.f -o up_sim
output=$(./obj_dir/up_sim +verilator+error+limit+1000 || true)
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -q "Everything OK"; then
   exit 0
fi
exit 1
